// ==== alu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   dec_valid,
  input  mips_pkg::alu_op_e      alu_op,
  input  logic                   use_imm,
  input  logic                   zero_ext,
  input  mips_pkg::instr_class_e iclass,
  input  logic [4:0]             rs,
  input  logic [4:0]             rt,
  input  logic [4:0]             dest,
  input  logic [15:0]            imm,
  input  logic [31:0]            pc,
  output logic [4:0]             ra_addr,
  output logic [4:0]             rb_addr,
  input  logic [31:0]            ra_data,
  input  logic [31:0]            rb_data,
  input  logic                   stall,
  output logic                   dec_stall,
  output logic                   ex_valid,
  output logic [31:0]            ex_value,
  output logic [4:0]             ex_dest,
  output logic                   ex_wen,
  output logic                   ex_taken,
  output logic [31:0]            ex_target,
  output logic                   ex_illegal
);

  logic [31:0] op_a;
  logic [31:0] op_rt;
  logic [31:0] op_b;
  logic [31:0] ext_imm;
  logic [31:0] alu_res;
  logic        is_alu;
  logic        is_br;
  logic        equal;
  logic        load;

  assign ra_addr   = rs;
  assign rb_addr   = rt;
  assign dec_stall = ex_valid && stall;      // Stall passes only while full
  assign load      = !ex_valid || !stall;

  // Held result not yet in the register file, forward it to the younger one
  assign op_a  = (ex_valid && ex_wen && ex_dest == rs) ? ex_value : ra_data;
  assign op_rt = (ex_valid && ex_wen && ex_dest == rt) ? ex_value : rb_data;

  assign ext_imm = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
  assign op_b    = use_imm ? ext_imm : op_rt;

  always_comb begin
    case (alu_op)
      mips_pkg::ALU_ADD:  alu_res = op_a + op_b;
      mips_pkg::ALU_SUB:  alu_res = op_a - op_b;
      mips_pkg::ALU_AND:  alu_res = op_a & op_b;
      mips_pkg::ALU_OR:   alu_res = op_a | op_b;
      mips_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      mips_pkg::ALU_SLT:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
      mips_pkg::ALU_SLTU: alu_res = {31'd0, op_a < op_b};
      default:            alu_res = {imm, 16'h0000};  // LUI
    endcase
  end

  assign is_alu = iclass == mips_pkg::CLASS_ALU;
  assign is_br  = iclass == mips_pkg::CLASS_BRANCH_EQ || iclass == mips_pkg::CLASS_BRANCH_NE;
  assign equal  = op_a == op_rt;             // Branch compare rs with rt

  always_ff @(posedge clk) begin
    if (reset) ex_valid <= 1'b0;
    else if (load) ex_valid <= dec_valid;
  end

  always_ff @(posedge clk) begin
    if (load && dec_valid) begin
      ex_value   <= is_alu ? alu_res : 32'd0;  // Zero for branch and illegal
      ex_dest    <= dest;
      ex_wen     <= is_alu && dest != 5'd0;
      ex_taken   <= (iclass == mips_pkg::CLASS_BRANCH_EQ && equal) ||
                    (iclass == mips_pkg::CLASS_BRANCH_NE && !equal);
      ex_target  <= is_br ? pc + 32'd4 + {{14{imm[15]}}, imm, 2'b00} : 32'd0;
      ex_illegal <= iclass == mips_pkg::CLASS_ILLEGAL;
    end
  end

endmodule

`default_nettype wire

// ==== main_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_decoder (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  logic [31:0]            in_instr,
  input  logic [31:0]            in_pc,
  input  logic                   stall,
  output logic                   dec_valid,
  output mips_pkg::alu_op_e      alu_op,
  output logic                   use_imm,
  output logic                   zero_ext,
  output mips_pkg::instr_class_e iclass,
  output logic [4:0]             rs,
  output logic [4:0]             rt,
  output logic [4:0]             dest,
  output logic [15:0]            imm,
  output logic [31:0]            pc,
  output logic                   in_credit
);

  mips_pkg::opcode_e      op;
  mips_pkg::funct_e       fn;
  mips_pkg::alu_op_e      nxt_alu_op;
  mips_pkg::instr_class_e nxt_iclass;
  logic                   nxt_use_imm;
  logic                   nxt_zero_ext;
  logic [4:0]             nxt_dest;
  logic                   take;

  assign op        = mips_pkg::opcode_e'(in_instr[31:26]);
  assign fn        = mips_pkg::funct_e'(in_instr[5:0]);
  assign take      = !dec_valid || !stall;   // Slot empty or leaving
  assign in_credit = dec_valid && !stall;    // Credit back on handoff

  always_comb begin
    nxt_alu_op   = mips_pkg::ALU_ADD;
    nxt_iclass   = mips_pkg::CLASS_ALU;
    nxt_use_imm  = 1'b1;                     // I-type default
    nxt_zero_ext = 1'b0;
    nxt_dest     = in_instr[20:16];          // I-type writes rt
    case (op)
      mips_pkg::OP_SPECIAL: begin
        nxt_use_imm = 1'b0;
        nxt_dest    = in_instr[15:11];       // R-type writes rd
        case (fn)
          mips_pkg::FN_ADDU: nxt_alu_op = mips_pkg::ALU_ADD;
          mips_pkg::FN_SUBU: nxt_alu_op = mips_pkg::ALU_SUB;
          mips_pkg::FN_AND:  nxt_alu_op = mips_pkg::ALU_AND;
          mips_pkg::FN_OR:   nxt_alu_op = mips_pkg::ALU_OR;
          mips_pkg::FN_XOR:  nxt_alu_op = mips_pkg::ALU_XOR;
          mips_pkg::FN_SLT:  nxt_alu_op = mips_pkg::ALU_SLT;
          mips_pkg::FN_SLTU: nxt_alu_op = mips_pkg::ALU_SLTU;
          default: begin
            nxt_iclass = mips_pkg::CLASS_ILLEGAL;  // Unknown funct
            nxt_dest   = 5'd0;
          end
        endcase
      end
      mips_pkg::OP_ADDIU: nxt_alu_op = mips_pkg::ALU_ADD;
      mips_pkg::OP_SLTI:  nxt_alu_op = mips_pkg::ALU_SLT;
      mips_pkg::OP_SLTIU: nxt_alu_op = mips_pkg::ALU_SLTU;  // Sign-extended, unsigned compare
      mips_pkg::OP_ANDI: begin
        nxt_alu_op   = mips_pkg::ALU_AND;
        nxt_zero_ext = 1'b1;
      end
      mips_pkg::OP_ORI: begin
        nxt_alu_op   = mips_pkg::ALU_OR;
        nxt_zero_ext = 1'b1;
      end
      mips_pkg::OP_XORI: begin
        nxt_alu_op   = mips_pkg::ALU_XOR;
        nxt_zero_ext = 1'b1;
      end
      mips_pkg::OP_LUI:   nxt_alu_op = mips_pkg::ALU_LUI;
      mips_pkg::OP_BEQ: begin
        nxt_iclass  = mips_pkg::CLASS_BRANCH_EQ;
        nxt_use_imm = 1'b0;                  // Compare rs with rt
        nxt_dest    = 5'd0;                  // No write
      end
      mips_pkg::OP_BNE: begin
        nxt_iclass  = mips_pkg::CLASS_BRANCH_NE;
        nxt_use_imm = 1'b0;
        nxt_dest    = 5'd0;
      end
      default: begin
        nxt_iclass  = mips_pkg::CLASS_ILLEGAL;  // Unknown opcode
        nxt_use_imm = 1'b0;
        nxt_dest    = 5'd0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) dec_valid <= 1'b0;
    else if (take) dec_valid <= in_valid;
  end

  always_ff @(posedge clk) begin
    if (take && in_valid) begin
      alu_op   <= nxt_alu_op;
      use_imm  <= nxt_use_imm;
      zero_ext <= nxt_zero_ext;
      iclass   <= nxt_iclass;
      rs       <= in_instr[25:21];
      rt       <= in_instr[20:16];
      dest     <= nxt_dest;
      imm      <= in_instr[15:0];
      pc       <= in_pc;
    end
  end

endmodule

`default_nettype wire

// ==== mips_exec_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_exec_assert (
  input logic clk,
  input logic reset,
  input logic in_valid,
  input logic in_credit,
  input logic res_valid,
  input logic res_credit
);

  int up_cnt;        // Credits held by upstream
  int out_cnt;       // Credits held by the core
  int fail_cnt = 0;  // Failed assertions so far

  always_ff @(posedge clk) begin
    if (reset) begin
      up_cnt  <= mips_pkg::IN_CREDITS;
      out_cnt <= mips_pkg::OUT_CREDITS;
    end else begin
      up_cnt  <= up_cnt + int'(in_credit) - int'(in_valid);     // Pulse and spend cancel
      out_cnt <= out_cnt + int'(res_credit) - int'(res_valid);
    end
  end

  a_res_has_credit: assert property (@(posedge clk) disable iff (reset)
    res_valid |-> out_cnt > 0)
    else begin
      $error("res_valid asserted with no result credit left");
      fail_cnt++;
    end

  a_in_has_credit: assert property (@(posedge clk) disable iff (reset)
    in_valid |-> (up_cnt + int'(in_credit)) > 0)
    else begin
      $error("in_valid sent beyond the returned instruction credits");
      fail_cnt++;
    end

  // Outputs quiet once reset has been applied
  a_quiet_in_reset: assert property (@(posedge clk)
    reset |=> (!in_credit && !res_valid))
    else begin
      $error("in_credit or res_valid high during reset");
      fail_cnt++;
    end

endmodule

bind mips_exec_top mips_exec_assert u_assert (
  .clk        (clk),
  .reset      (reset),
  .in_valid   (in_valid),
  .in_credit  (in_credit),
  .res_valid  (res_valid),
  .res_credit (res_credit)
);

`default_nettype wire

// ==== mips_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_exec_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        in_valid,
  input  logic [31:0] in_instr,
  input  logic [31:0] in_pc,
  output logic        in_credit,
  output logic        res_valid,
  output logic [4:0]  res_dest,
  output logic [31:0] res_value,
  output logic        res_wen,
  output logic        res_taken,
  output logic [31:0] res_target,
  output logic        res_illegal,
  input  logic        res_credit
);

  // Decode to execute
  logic                   dec_valid;
  logic                   dec_stall;
  mips_pkg::alu_op_e      alu_op;
  mips_pkg::instr_class_e iclass;
  logic                   use_imm;
  logic                   zero_ext;
  logic [4:0]             rs;
  logic [4:0]             rt;
  logic [4:0]             dest;
  logic [15:0]            imm;
  logic [31:0]            pc;

  // Register file read and write-back
  logic [4:0]  ra_addr;
  logic [4:0]  rb_addr;
  logic [31:0] ra_data;
  logic [31:0] rb_data;
  logic        wb_en;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;

  // Execute to result
  logic        ex_valid;
  logic        ex_stall;
  logic [31:0] ex_value;
  logic [4:0]  ex_dest;
  logic        ex_wen;
  logic        ex_taken;
  logic [31:0] ex_target;
  logic        ex_illegal;

  main_decoder u_dec (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .in_pc     (in_pc),
    .stall     (dec_stall),                  // From execute
    .dec_valid (dec_valid),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .zero_ext  (zero_ext),
    .iclass    (iclass),
    .rs        (rs),
    .rt        (rt),
    .dest      (dest),
    .imm       (imm),
    .pc        (pc),
    .in_credit (in_credit)
  );

  reg_file u_rf (
    .clk     (clk),
    .reset   (reset),
    .ra_addr (ra_addr),
    .rb_addr (rb_addr),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

  alu_exec u_ex (
    .clk        (clk),
    .reset      (reset),
    .dec_valid  (dec_valid),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .zero_ext   (zero_ext),
    .iclass     (iclass),
    .rs         (rs),
    .rt         (rt),
    .dest       (dest),
    .imm        (imm),
    .pc         (pc),
    .ra_addr    (ra_addr),
    .rb_addr    (rb_addr),
    .ra_data    (ra_data),
    .rb_data    (rb_data),
    .stall      (ex_stall),                  // From result stage
    .dec_stall  (dec_stall),
    .ex_valid   (ex_valid),
    .ex_value   (ex_value),
    .ex_dest    (ex_dest),
    .ex_wen     (ex_wen),
    .ex_taken   (ex_taken),
    .ex_target  (ex_target),
    .ex_illegal (ex_illegal)
  );

  result_stage u_res (
    .clk         (clk),
    .reset       (reset),
    .ex_valid    (ex_valid),
    .ex_value    (ex_value),
    .ex_dest     (ex_dest),
    .ex_wen      (ex_wen),
    .ex_taken    (ex_taken),
    .ex_target   (ex_target),
    .ex_illegal  (ex_illegal),
    .res_credit  (res_credit),
    .ex_stall    (ex_stall),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data),
    .res_valid   (res_valid),
    .res_dest    (res_dest),
    .res_value   (res_value),
    .res_wen     (res_wen),
    .res_taken   (res_taken),
    .res_target  (res_target),
    .res_illegal (res_illegal)
  );

endmodule

`default_nettype wire

// ==== mips_pkg.sv ====
`default_nettype none

package mips_pkg;

  // Primary opcodes of the supported subset
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'b000000,  // R-type, selected by funct
    OP_BEQ     = 6'b000100,
    OP_BNE     = 6'b000101,
    OP_ADDIU   = 6'b001001,
    OP_SLTI    = 6'b001010,
    OP_SLTIU   = 6'b001011,
    OP_ANDI    = 6'b001100,  // Zero-extended immediate
    OP_ORI     = 6'b001101,  // Zero-extended immediate
    OP_XORI    = 6'b001110,  // Zero-extended immediate
    OP_LUI     = 6'b001111
  } opcode_e;

  // Funct field of the supported R-type instructions
  typedef enum logic [5:0] {
    FN_ADDU = 6'b100001,
    FN_SUBU = 6'b100011,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101,
    FN_XOR  = 6'b100110,
    FN_SLT  = 6'b101010,  // Signed compare
    FN_SLTU = 6'b101011   // Unsigned compare
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_LUI   // Immediate into upper half
  } alu_op_e;

  typedef enum logic [1:0] {
    CLASS_ALU,
    CLASS_BRANCH_EQ,
    CLASS_BRANCH_NE,
    CLASS_ILLEGAL
  } instr_class_e;

  localparam int IN_CREDITS  = 1;  // One decode slot
  localparam int OUT_CREDITS = 4;  // Sink buffer depth
  localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1);  // Counts 0..OUT_CREDITS

endpackage

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  ra_addr,
  input  logic [4:0]  rb_addr,
  output logic [31:0] ra_data,
  output logic [31:0] rb_data,
  input  logic        wb_en,
  input  logic [4:0]  wb_addr,
  input  logic [31:0] wb_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;                          // All registers start at zero
      end
    end else if (wb_en && wb_addr != 5'd0) begin
      regs[wb_addr] <= wb_data;                 // Register zero never written
    end
  end

  // Write in progress is visible to readers in the same cycle
  always_comb begin
    if (ra_addr == 5'd0) ra_data = '0;
    else if (wb_en && wb_addr == ra_addr) ra_data = wb_data;  // Bypass
    else ra_data = regs[ra_addr];
  end

  always_comb begin
    if (rb_addr == 5'd0) rb_data = '0;
    else if (wb_en && wb_addr == rb_addr) rb_data = wb_data;  // Bypass
    else rb_data = regs[rb_addr];
  end

endmodule

`default_nettype wire

// ==== result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_stage (
  input  logic        clk,
  input  logic        reset,
  input  logic        ex_valid,
  input  logic [31:0] ex_value,
  input  logic [4:0]  ex_dest,
  input  logic        ex_wen,
  input  logic        ex_taken,
  input  logic [31:0] ex_target,
  input  logic        ex_illegal,
  input  logic        res_credit,
  output logic        ex_stall,
  output logic        wb_en,
  output logic [4:0]  wb_addr,
  output logic [31:0] wb_data,
  output logic        res_valid,
  output logic [4:0]  res_dest,
  output logic [31:0] res_value,
  output logic        res_wen,
  output logic        res_taken,
  output logic [31:0] res_target,
  output logic        res_illegal
);

  logic                          full;
  logic [mips_pkg::CREDIT_W-1:0] credits;
  logic                          have_credit;
  logic                          load;

  assign have_credit = credits != '0;
  assign res_valid   = full && have_credit;  // One cycle, then slot frees
  assign ex_stall    = full && !have_credit;
  assign load        = ex_valid && !ex_stall;

  // Write repeats while the record waits, so younger reads see it too
  assign wb_en   = full && res_wen;
  assign wb_addr = res_dest;
  assign wb_data = res_value;

  always_ff @(posedge clk) begin
    if (reset) full <= 1'b0;
    else if (load) full <= 1'b1;
    else if (res_valid) full <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= mips_pkg::OUT_CREDITS[mips_pkg::CREDIT_W-1:0];
    end else begin
      case ({res_credit, res_valid})
        2'b10:   credits <= credits + 1'b1;  // Returned by sink
        2'b01:   credits <= credits - 1'b1;  // Spent on a record
        default: credits <= credits;         // Both or neither cancel
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      res_value   <= ex_value;
      res_dest    <= ex_dest;
      res_wen     <= ex_wen;
      res_taken   <= ex_taken;
      res_target  <= ex_target;
      res_illegal <= ex_illegal;
    end
  end

endmodule

`default_nettype wire

// ==== src.f ====
mips_pkg.sv
reg_file.sv
main_decoder.sv
alu_exec.sv
result_stage.sv
mips_exec_top.sv
mips_exec_assert.sv
tb_mips_exec.sv

// ==== tb_mips_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_exec;

  typedef struct packed {
    logic [4:0]  dest;
    logic [31:0] value;
    logic        wen;
    logic        taken;
    logic [31:0] target;
    logic        illegal;
  } exp_rec_t;

  logic        clk;
  logic        reset;
  logic        in_valid;
  logic [31:0] in_instr;
  logic [31:0] in_pc;
  logic        in_credit;
  logic        res_valid;
  logic [4:0]  res_dest;
  logic [31:0] res_value;
  logic        res_wen;
  logic        res_taken;
  logic [31:0] res_target;
  logic        res_illegal;
  logic        res_credit;

  exp_rec_t    exp_q [$];          // Expected records in program order
  logic [31:0] prog [$];
  logic [31:0] model_regs [32];    // Architectural state of the model
  int          ret_q [$];          // Cycles at which sink returns credits
  integer      seed = 32'h98a4_2aec;
  int          slow_start = 0;
  int          credits_back = 0;
  int          credits_spent = 0;
  int          results_seen = 0;
  int          cycle_cnt = 0;
  int          last_due = 0;       // Latest scheduled credit return
  logic        slow_sink = 1'b0;

  mips_exec_top u_mips_exec_top (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_instr    (in_instr),
    .in_pc       (in_pc),
    .in_credit   (in_credit),
    .res_valid   (res_valid),
    .res_dest    (res_dest),
    .res_value   (res_value),
    .res_wen     (res_wen),
    .res_taken   (res_taken),
    .res_target  (res_target),
    .res_illegal (res_illegal),
    .res_credit  (res_credit)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;           // 40 ns period

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd);
    return {6'b000000, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [5:0] funct_of(input logic [2:0] k);
    case (k)
      3'd0:    return mips_pkg::FN_ADDU;
      3'd1:    return mips_pkg::FN_SUBU;
      3'd2:    return mips_pkg::FN_AND;
      3'd3:    return mips_pkg::FN_OR;
      3'd4:    return mips_pkg::FN_XOR;
      3'd5:    return mips_pkg::FN_SLT;
      default: return mips_pkg::FN_SLTU;     // Two codes land here
    endcase
  endfunction

  function automatic logic [5:0] iop_of(input logic [2:0] k);
    case (k)
      3'd1:    return mips_pkg::OP_SLTI;
      3'd2:    return mips_pkg::OP_SLTIU;
      3'd3:    return mips_pkg::OP_ANDI;
      3'd4:    return mips_pkg::OP_ORI;
      3'd5:    return mips_pkg::OP_XORI;
      3'd6:    return mips_pkg::OP_LUI;
      default: return mips_pkg::OP_ADDIU;
    endcase
  endfunction

  // Executes one instruction on the model and gives the record it must produce
  function automatic exp_rec_t ref_model(input logic [31:0] instr, input logic [31:0] pc);
    exp_rec_t    r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] zimm;
    a    = model_regs[instr[25:21]];
    b    = model_regs[instr[20:16]];
    simm = {{16{instr[15]}}, instr[15:0]};
    zimm = {16'h0000, instr[15:0]};
    r    = '0;
    r.dest = instr[20:16];                   // I-type writes rt
    case (instr[31:26])
      mips_pkg::OP_SPECIAL: begin
        r.dest = instr[15:11];
        case (instr[5:0])
          mips_pkg::FN_ADDU: r.value = a + b;
          mips_pkg::FN_SUBU: r.value = a - b;
          mips_pkg::FN_AND:  r.value = a & b;
          mips_pkg::FN_OR:   r.value = a | b;
          mips_pkg::FN_XOR:  r.value = a ^ b;
          mips_pkg::FN_SLT:  r.value = {31'd0, $signed(a) < $signed(b)};
          mips_pkg::FN_SLTU: r.value = {31'd0, a < b};
          default: begin
            r.dest    = 5'd0;
            r.illegal = 1'b1;
          end
        endcase
      end
      mips_pkg::OP_ADDIU: r.value = a + simm;
      mips_pkg::OP_SLTI:  r.value = {31'd0, $signed(a) < $signed(simm)};
      mips_pkg::OP_SLTIU: r.value = {31'd0, a < simm};
      mips_pkg::OP_ANDI:  r.value = a & zimm;
      mips_pkg::OP_ORI:   r.value = a | zimm;
      mips_pkg::OP_XORI:  r.value = a ^ zimm;
      mips_pkg::OP_LUI:   r.value = {instr[15:0], 16'h0000};
      mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
        r.dest   = 5'd0;
        r.taken  = (a == b) ^ (instr[31:26] == mips_pkg::OP_BNE);
        r.target = pc + 32'd4 + {simm[29:0], 2'b00};
      end
      default: begin
        r.dest    = 5'd0;
        r.illegal = 1'b1;
      end
    endcase
    r.wen = r.dest != 5'd0;                  // Branch and illegal carry dest zero
    if (r.wen)
      model_regs[r.dest] = r.value;
    return r;
  endfunction

  task automatic build_program();
    logic [31:0] rnd;
    logic [4:0]  prev;
    logic [4:0]  dst;
    for (int i = 1; i < 32; i++) begin      // Random contents in every register
      rnd = rand32();
      prog.push_back(enc_i(mips_pkg::OP_LUI, 5'd0, 5'(i), rnd[31:16]));
      prog.push_back(enc_i(mips_pkg::OP_ORI, 5'(i), 5'(i), rnd[15:0]));
    end
    for (int i = 0; i < 40; i++) begin
      rnd = rand32();
      prog.push_back(enc_r(funct_of(rnd[2:0]), rnd[7:3], rnd[12:8], rnd[17:13]));
    end
    prog.push_back(enc_i(mips_pkg::OP_LUI, 5'd0, 5'd20, 16'h8000));   // Negative value
    prog.push_back(enc_i(mips_pkg::OP_ADDIU, 5'd0, 5'd21, 16'h0005));
    prog.push_back(enc_r(mips_pkg::FN_SLT, 5'd20, 5'd21, 5'd22));      // Signed gives 1
    prog.push_back(enc_r(mips_pkg::FN_SLTU, 5'd20, 5'd21, 5'd23));     // Unsigned gives 0
    for (int i = 0; i < 30; i++) begin
      rnd = rand32();
      prog.push_back(enc_i(iop_of(rnd[2:0]), rnd[7:3], rnd[12:8], rnd[31:16]));
    end
    prog.push_back(enc_i(mips_pkg::OP_ADDIU, 5'd0, 5'd24, 16'hfff0));  // Sign extended
    prog.push_back(enc_i(mips_pkg::OP_ANDI, 5'd24, 5'd25, 16'hfff0));  // Zero extended
    prog.push_back(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd26, 16'h8001));
    prog.push_back(enc_i(mips_pkg::OP_XORI, 5'd24, 5'd27, 16'hffff));
    prog.push_back(enc_i(mips_pkg::OP_ADDIU, 5'd5, 5'd0, 16'h1234));   // Write to r0
    prog.push_back(enc_i(mips_pkg::OP_LUI, 5'd0, 5'd0, 16'habcd));
    prog.push_back(enc_r(mips_pkg::FN_ADDU, 5'd0, 5'd0, 5'd28));       // r0 still zero
    prog.push_back(enc_i(mips_pkg::OP_BEQ, 5'd3, 5'd3, 16'hfffc));     // Taken, backward
    prog.push_back(enc_i(mips_pkg::OP_BNE, 5'd3, 5'd3, 16'h0010));     // Not taken
    for (int i = 0; i < 10; i++) begin
      rnd = rand32();
      prog.push_back(enc_i(rnd[0] ? mips_pkg::OP_BNE : mips_pkg::OP_BEQ, rnd[7:3],
                           rnd[1] ? rnd[7:3] : rnd[12:8], rnd[31:16]));
    end
    prog.push_back(enc_i(6'b100011, 5'd1, 5'd2, 16'h0004));            // LW, not supported
    prog.push_back(enc_i(6'b000010, 5'd0, 5'd0, 16'h0100));            // J
    prog.push_back(enc_r(6'b001000, 5'd31, 5'd0, 5'd0));               // JR
    prog.push_back(enc_r(mips_pkg::FN_ADDU, 5'd1, 5'd2, 5'd7));        // Dependent chain
    prog.push_back(enc_r(mips_pkg::FN_ADDU, 5'd7, 5'd7, 5'd8));
    prog.push_back(enc_r(mips_pkg::FN_SUBU, 5'd8, 5'd7, 5'd9));
    prog.push_back(enc_i(mips_pkg::OP_ADDIU, 5'd9, 5'd9, 16'h0005));
    prog.push_back(enc_r(mips_pkg::FN_XOR, 5'd9, 5'd9, 5'd10));
    prog.push_back(enc_r(mips_pkg::FN_OR, 5'd10, 5'd8, 5'd10));
    prog.push_back(enc_r(mips_pkg::FN_SLTU, 5'd10, 5'd9, 5'd11));
    slow_start = prog.size();
    prev = 5'd7;
    for (int i = 0; i < 40; i++) begin      // Chained ops under a slow sink
      rnd = rand32();
      dst = (rnd[4:0] == 5'd0) ? 5'd1 : rnd[4:0];
      if (rnd[5])
        prog.push_back(enc_r(funct_of(rnd[8:6]), prev, rnd[13:9], dst));
      else
        prog.push_back(enc_i(iop_of(rnd[8:6]), prev, dst, rnd[31:16]));
      prev = dst;
    end
  endtask

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: result %0d %s is %h, expected %h",
               $time, results_seen, what, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  initial begin : stimulus
    int          idx;
    logic [31:0] rnd;
    reset    = 1'b1;
    in_valid = 1'b0;
    in_instr = '0;
    in_pc    = '0;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    build_program();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    idx = 0;
    while (idx < prog.size()) begin
      @(negedge clk);
      rnd = rand32();
      if (mips_pkg::IN_CREDITS + credits_back - credits_spent > 0 &&
          (idx >= slow_start || rnd[1:0] != 2'b00)) begin  // Occasional idle cycle
        in_valid  = 1'b1;
        in_instr  = prog[idx];
        in_pc     = 32'h0040_0000 + idx * 4;
        slow_sink = idx >= slow_start;
        exp_q.push_back(ref_model(prog[idx], in_pc));
        credits_spent++;
        idx++;
      end else begin
        in_valid = 1'b0;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    wait (results_seen == prog.size());
    repeat (20) @(negedge clk);             // Catch any extra record
    if (credits_back != credits_spent) begin
      $display("Instruction credits returned %0d do not match %0d instructions sent",
               credits_back, credits_spent);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Instruction credit mismatch");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  always @(posedge clk) begin : count_in_credits
    if (!reset && in_credit)
      credits_back++;
  end

  always @(posedge clk) begin : sink_accept
    int delay;
    int due;
    cycle_cnt++;
    if (!reset && res_valid) begin
      delay = slow_sink ? 6 : $unsigned($random(seed)) % 7;
      due   = cycle_cnt + delay;
      if (slow_sink && last_due + delay > due)
        due = last_due + delay;             // Slow sink drains one record at a time
      ret_q.push_back(due);                 // One pulse per record
      last_due = due;
    end
  end

  initial begin : sink_credit
    res_credit = 1'b0;
    forever begin
      @(negedge clk);
      if (ret_q.size() != 0 && ret_q[0] <= cycle_cnt) begin
        void'(ret_q.pop_front());
        res_credit = 1'b1;
      end else begin
        res_credit = 1'b0;
      end
    end
  end

  always @(posedge clk) begin : compare_results
    exp_rec_t e;
    if (!reset && res_valid) begin
      if (exp_q.size() == 0) begin
        $display("ERROR at %0t ns: result record with no instruction outstanding", $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Unexpected result record");
      end else begin
        e = exp_q.pop_front();
        check_equal("res_dest", 32'(res_dest), 32'(e.dest));
        check_equal("res_value", res_value, e.value);
        check_equal("res_wen", 32'(res_wen), 32'(e.wen));
        check_equal("res_taken", 32'(res_taken), 32'(e.taken));
        check_equal("res_target", res_target, e.target);
        check_equal("res_illegal", 32'(res_illegal), 32'(e.illegal));
        results_seen++;
      end
    end
  end

  always @(negedge clk) begin : assert_monitor
    if (u_mips_exec_top.u_assert.fail_cnt != 0) begin
      $display("A protocol assertion on the credit handshake or reset failed");
      $display("TEST RESULT: FAIL");
      $fatal(1, "Assertion failure");
    end
  end

  initial begin : watchdog
    @(negedge reset);
    repeat (40 * prog.size() + 200) @(posedge clk);
    $display("Watchdog expired, results stopped arriving after %0d of %0d",
             results_seen, prog.size());
    $display("TEST RESULT: FAIL");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire
